// File: design/frontEnd_defines.svh
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Address bus width of the front end
`define FE_ADDR_WIDTH 16

// Opcode width, one byte as on the 6502
`define FE_OPCODE_WIDTH 8

// Break opcode injected for reset, NMI and IRQ
`define FE_BRK_OPCODE 8'h00

// Service vector addresses, low byte of each pair
`define FE_NMI_VECTOR 16'hFFFA
`define FE_RESET_VECTOR 16'hFFFC
`define FE_IRQ_VECTOR 16'hFFFE

// Vector reported with a normal fetched byte
`define FE_NO_VECTOR 16'h0000

`endif

// File: design/frontEndPkg.sv
`include "frontEnd_defines.svh"

package frontEndPkg;

    // One instruction byte
    typedef logic [`FE_OPCODE_WIDTH-1:0] opcodeT;

    // Memory address as seen by the fetch stage and the core
    typedef logic [`FE_ADDR_WIDTH-1:0] addrT;

    // Where a dispatched opcode came from
    // Encoding rises with service priority
    // srcNone marks a plain memory byte
    typedef enum logic [1:0]
    {
        srcNone  = 2'd0,
        srcIrq   = 2'd1,
        srcNmi   = 2'd2,
        srcReset = 2'd3
    } interruptSourceT;

endpackage

// File: design/opcodeFetcher.sv
`timescale 1ns/1ps

module opcodeFetcher
    import frontEndPkg::*;
(
    input  logic   clk,
    input  logic   resetDetected,
    output logic   memReq,
    output addrT   memAddr,
    input  logic   memAck,
    input  opcodeT memData,
    input  logic   jumpValid,
    input  addrT   jumpTarget,
    input  logic   consume,
    output logic   byteValid,
    output opcodeT fetchedByte
);

    // Memory handshake states
    // stDiscard keeps the request up but drops the returned byte
    typedef enum logic [1:0]
    {
        stIdle        = 2'd0,
        stRequest     = 2'd1,
        stWaitRelease = 2'd2,
        stDiscard     = 2'd3
    } fetchStateT;

    fetchStateT state;
    addrT       pc;
    addrT       reqAddr;
    logic       held;
    opcodeT     holdByte;
    logic       ackSeen;

    // Edge that closes phase 2 of the memory handshake
    assign ackSeen = (state == stRequest) && memAck;

    // Request stays up until the ack arrives, also when discarding
    assign memReq = (state == stRequest) || (state == stDiscard);
    assign memAddr = reqAddr;

    // Held byte is hidden in the jump cycle
    assign byteValid = held && !jumpValid;
    assign fetchedByte = holdByte;

    always_ff @(posedge clk)
    begin
        if (resetDetected)
        begin
            state <= stIdle;
            pc <= '0;
            held <= 1'b0;
        end
        else
        begin
            case (state)
                stIdle:
                begin
                    // Back-pressure, no fetch while a byte sits in the hold
                    if (!held && !jumpValid)
                        state <= stRequest;
                end
                stRequest:
                begin
                    if (memAck)
                        state <= stWaitRelease;
                    else if (jumpValid)
                        state <= stDiscard;
                end
                stDiscard:
                begin
                    // Stale address, finish the transaction and drop the data
                    if (memAck)
                        state <= stWaitRelease;
                end
                default:
                begin
                    // Phase 4, memory must release its ack first
                    if (!memAck)
                        state <= stIdle;
                end
            endcase

            // Jump beats consume and any returning byte
            if (jumpValid)
            begin
                held <= 1'b0;
                pc <= jumpTarget;
            end
            else if (consume && held)
            begin
                held <= 1'b0;
                pc <= pc + addrT'(1);
            end
            else if (ackSeen)
                held <= 1'b1;
        end
    end

    // Byte and address registers, loaded only on their own events
    always_ff @(posedge clk)
    begin
        if (ackSeen && !jumpValid)
            holdByte <= memData;
        // Address frozen once the request is up
        if (state == stIdle)
            reqAddr <= pc;
    end

endmodule

// File: design/interruptInjector.sv
`timescale 1ns/1ps

module interruptInjector
    import frontEndPkg::*;
(
    input  logic            clk,
    input  logic            resetDetected,
    input  logic            nonMaskableInterrupt,
    input  logic            interruptRequest,
    input  logic            processStatusRegIFlag,
    input  logic            capture,
    output interruptSourceT injectSource
);

    logic nmiPrev;
    logic nmiLatch;
    logic resetPending;
    logic nmiEdge;
    logic irqPending;
    logic serviceNmi;
    logic serviceReset;

    // NMI is edge triggered, a level held high fires once
    assign nmiEdge = nonMaskableInterrupt && !nmiPrev;

    // IRQ is level sensitive and masked by the I flag
    assign irqPending = interruptRequest && !processStatusRegIFlag;

    // Fixed priority, reset first, then NMI, then IRQ
    always_comb
    begin
        if (resetPending)
            injectSource = srcReset;
        else if (nmiLatch)
            injectSource = srcNmi;
        else if (irqPending)
            injectSource = srcIrq;
        else
            injectSource = srcNone;
    end

    // Source taken by the dispatch stage this cycle
    assign serviceNmi = capture && (injectSource == srcNmi);
    assign serviceReset = capture && (injectSource == srcReset);

    always_ff @(posedge clk)
    begin
        if (resetDetected)
        begin
            // Reset break is queued for the first capture
            resetPending <= 1'b1;
            nmiLatch <= 1'b0;
            nmiPrev <= 1'b0;
        end
        else
        begin
            nmiPrev <= nonMaskableInterrupt;

            if (serviceReset)
                resetPending <= 1'b0;

            // A fresh edge in the service cycle stays pending
            if (nmiEdge)
                nmiLatch <= 1'b1;
            else if (serviceNmi)
                nmiLatch <= 1'b0;
        end
    end

    // IRQ needs no state, it is sampled at the capture edge
    // and stays pending as long as the line is held and unmasked

endmodule

// File: design/instructionLoader.sv
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module instructionLoader
    import frontEndPkg::*;
(
    input  logic            clk,
    input  logic            resetDetected,
    input  logic            nonMaskableInterrupt,
    input  logic            interruptRequest,
    input  logic            processStatusRegIFlag,
    input  logic            byteValid,
    input  opcodeT          fetchedByte,
    input  logic            capture,
    output logic            consume,
    output logic            itemReady,
    output opcodeT          nextInstruction,
    output interruptSourceT nextSource,
    output logic            enableIFlag
);

    interruptSourceT injectSource;
    logic            injectPending;

    // Pending reset, NMI and IRQ arbitration
    interruptInjector interruptInjector
    (
        .clk(clk),
        .resetDetected(resetDetected),
        .nonMaskableInterrupt(nonMaskableInterrupt),
        .interruptRequest(interruptRequest),
        .processStatusRegIFlag(processStatusRegIFlag),
        .capture(capture),
        .injectSource(injectSource)
    );

    assign injectPending = (injectSource != srcNone);

    // Something to hand over, a held byte or a break
    assign itemReady = byteValid || injectPending;

    // Break opcode replaces the memory byte while a source is pending
    assign nextInstruction = injectPending ? `FE_BRK_OPCODE : fetchedByte;
    assign nextSource = injectSource;

    // Held byte survives an injected break and goes out later
    assign consume = capture && !injectPending && byteValid;

    // I flag set when the core starts servicing a break
    assign enableIFlag = capture && injectPending;

endmodule

// File: design/instructionDispatcher.sv
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module instructionDispatcher
    import frontEndPkg::*;
(
    input  logic            clk,
    input  logic            resetDetected,
    input  logic            coreReq,
    output logic            coreAck,
    input  logic            itemReady,
    input  opcodeT          nextInstruction,
    input  interruptSourceT nextSource,
    output logic            capture,
    output opcodeT          instruction,
    output interruptSourceT instrSource,
    output addrT            vector
);

    // Service vector for each source
    function automatic addrT vectorFor(input interruptSourceT src);
        addrT result;
        case (src)
            srcReset: result = `FE_RESET_VECTOR;
            srcNmi:   result = `FE_NMI_VECTOR;
            srcIrq:   result = `FE_IRQ_VECTOR;
            default:  result = `FE_NO_VECTOR;
        endcase
        return result;
    endfunction

    // Phase 1 seen with no ack out, take the item if one is ready
    // Variable latency while the loader has nothing to offer
    assign capture = coreReq && !coreAck && itemReady;

    always_ff @(posedge clk)
    begin
        if (resetDetected)
            coreAck <= 1'b0;
        else if (capture)
            coreAck <= 1'b1;
        else if (coreAck && !coreReq)
            // Phase 4 after the core drops its request
            coreAck <= 1'b0;
    end

    // Outputs only move on capture, so they stay put while coreAck is up
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            instruction <= nextInstruction;
            instrSource <= nextSource;
            vector <= vectorFor(nextSource);
        end
    end

endmodule

// File: design/instructionFrontEnd.sv
`timescale 1ns/1ps

module instructionFrontEnd
    import frontEndPkg::*;
(
    input  logic            clk,
    input  logic            resetDetected,
    output logic            memReq,
    output addrT            memAddr,
    input  logic            memAck,
    input  opcodeT          memData,
    input  logic            coreReq,
    output logic            coreAck,
    output opcodeT          instruction,
    output interruptSourceT instrSource,
    output addrT            vector,
    input  logic            jumpValid,
    input  addrT            jumpTarget,
    input  logic            nonMaskableInterrupt,
    input  logic            interruptRequest,
    input  logic            processStatusRegIFlag,
    output logic            enableIFlag
);

    // Fetch to load
    logic            byteValid;
    opcodeT          fetchedByte;
    logic            consume;

    // Load to dispatch
    logic            capture;
    logic            itemReady;
    opcodeT          nextInstruction;
    interruptSourceT nextSource;

    opcodeFetcher opcodeFetcher
    (
        .clk(clk),
        .resetDetected(resetDetected),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memData(memData),
        .jumpValid(jumpValid),
        .jumpTarget(jumpTarget),
        .consume(consume),
        .byteValid(byteValid),
        .fetchedByte(fetchedByte)
    );

    instructionLoader instructionLoader
    (
        .clk(clk),
        .resetDetected(resetDetected),
        .nonMaskableInterrupt(nonMaskableInterrupt),
        .interruptRequest(interruptRequest),
        .processStatusRegIFlag(processStatusRegIFlag),
        .byteValid(byteValid),
        .fetchedByte(fetchedByte),
        .capture(capture),
        .consume(consume),
        .itemReady(itemReady),
        .nextInstruction(nextInstruction),
        .nextSource(nextSource),
        .enableIFlag(enableIFlag)
    );

    instructionDispatcher instructionDispatcher
    (
        .clk(clk),
        .resetDetected(resetDetected),
        .coreReq(coreReq),
        .coreAck(coreAck),
        .itemReady(itemReady),
        .nextInstruction(nextInstruction),
        .nextSource(nextSource),
        .capture(capture),
        .instruction(instruction),
        .instrSource(instrSource),
        .vector(vector)
    );

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen
#(
    parameter int periodNs = 20,
    parameter int resetCycles = 4
)
(
    output logic clk,
    output logic resetDetected
);

    // Free running clock, low at time zero
    initial
    begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset held over a fixed number of rising edges
    initial
    begin
        resetDetected = 1'b1;
        repeat (resetCycles) @(posedge clk);
        // Released on a falling edge like every other input
        @(negedge clk);
        resetDetected = 1'b0;
    end

endmodule

// File: verification/frontEndTb.sv
`timescale 1ns/1ps
`include "frontEnd_defines.svh"

module frontEndTb
    import frontEndPkg::*;
();

    localparam int numTransactions = 200;
    localparam int cyclesPerTransaction = 40;
    localparam int clkPeriod = 20;

    logic            clk;
    logic            resetDetected;
    logic            memReq;
    addrT            memAddr;
    logic            memAck;
    opcodeT          memData;
    logic            coreReq;
    logic            coreAck;
    opcodeT          instruction;
    interruptSourceT instrSource;
    addrT            vector;
    logic            jumpValid;
    addrT            jumpTarget;
    logic            nonMaskableInterrupt;
    logic            interruptRequest;
    logic            processStatusRegIFlag;
    logic            enableIFlag;

    // Program memory image
    opcodeT mem [0:65535];

    // Reference model state
    addrT   expPc;
    logic   modelResetPending;
    logic   modelNmiLatch;
    logic   modelNmiPrev;

    // Values seen at the previous rising edge
    logic            sampleValid;
    logic            lastReset;
    logic            lastNmi;
    logic            lastIrq;
    logic            lastIFlag;
    logic            lastJump;
    addrT            lastTarget;
    logic            lastEnable;
    logic            lastCoreReq;
    logic            lastCoreAck;
    logic            lastMemReq;
    logic            lastMemAck;
    addrT            lastMemAddr;
    opcodeT          lastInstr;
    interruptSourceT lastSource;
    addrT            lastVector;

    int valueErrors;
    int protocolErrors;
    int captureCount;
    int txnCount;

    clockGen #(.periodNs(clkPeriod), .resetCycles(4)) clockGen
    (
        .clk(clk),
        .resetDetected(resetDetected)
    );

    instructionFrontEnd dut
    (
        .clk(clk),
        .resetDetected(resetDetected),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memData(memData),
        .coreReq(coreReq),
        .coreAck(coreAck),
        .instruction(instruction),
        .instrSource(instrSource),
        .vector(vector),
        .jumpValid(jumpValid),
        .jumpTarget(jumpTarget),
        .nonMaskableInterrupt(nonMaskableInterrupt),
        .interruptRequest(interruptRequest),
        .processStatusRegIFlag(processStatusRegIFlag),
        .enableIFlag(enableIFlag)
    );

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        valueErrors++;
        $display("ERROR %s at %0t: expected %0h, actual %0h", testName, $time, expected, actual);
    endtask

    task automatic flagProtocol(input string what);
        protocolErrors++;
        $display("Protocol violation at %0t: %s", $time, what);
    endtask

    // Memory slave with a random ack delay of 0 to 5 cycles
    task automatic runMemory();
        int delay;
        forever
        begin
            @(negedge clk);
            if (memReq && !memAck)
            begin
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                memData = mem[memAddr];
                memAck = 1'b1;
                do @(negedge clk); while (memReq);
                memAck = 1'b0;
            end
        end
    endtask

    // Jumps, interrupt lines and I flag toggled at random
    task automatic driveInterrupts();
        wait (!resetDetected);
        forever
        begin
            @(negedge clk);
            jumpValid = !jumpValid && ($urandom % 50 == 0);
            if (jumpValid)
                jumpTarget = addrT'($urandom);
            if ($urandom % 20 == 0)
                nonMaskableInterrupt = !nonMaskableInterrupt;
            if ($urandom % 15 == 0)
                interruptRequest = !interruptRequest;
            if ($urandom % 10 == 0)
                processStatusRegIFlag = !processStatusRegIFlag;
        end
    endtask

    // Core side requester with random gaps
    task automatic runCore();
        int gap;
        wait (!resetDetected);
        // One cycle for the NMI edge to reach its latch
        @(negedge clk);
        while (txnCount < numTransactions)
        begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            coreReq = 1'b1;
            do @(negedge clk); while (!coreAck);
            coreReq = 1'b0;
            txnCount++;
            do @(negedge clk); while (coreAck);
        end
    endtask

    // Capture at an edge is known one edge later, when coreAck has risen
    always @(posedge clk)
    begin
        interruptSourceT expSrc;
        opcodeT          expOp;
        addrT            expVec;
        logic            captured;
        if (sampleValid && lastReset)
        begin
            expPc = '0;
            modelResetPending = 1'b1;
            modelNmiLatch = 1'b0;
            modelNmiPrev = 1'b0;
            assert (!memReq && !coreAck)
            else flagProtocol("memReq or coreAck high right after reset");
        end
        else if (sampleValid)
        begin
            captured = coreAck && !lastCoreAck;
            // Reset, then NMI, then unmasked IRQ, then a plain byte
            if (modelResetPending)
            begin
                expSrc = srcReset;
                expVec = `FE_RESET_VECTOR;
            end
            else if (modelNmiLatch)
            begin
                expSrc = srcNmi;
                expVec = `FE_NMI_VECTOR;
            end
            else if (lastIrq && !lastIFlag)
            begin
                expSrc = srcIrq;
                expVec = `FE_IRQ_VECTOR;
            end
            else
            begin
                expSrc = srcNone;
                expVec = 16'h0000;
            end
            expOp = (expSrc == srcNone) ? mem[expPc] : `FE_BRK_OPCODE;

            assert (lastEnable == (captured && expSrc != srcNone))
            else reportMismatch("enableIFlag", captured && expSrc != srcNone, lastEnable);
            if (captured)
            begin
                captureCount++;
                assert (instruction == expOp)
                else reportMismatch("opcode", expOp, instruction);
                assert (instrSource == expSrc)
                else reportMismatch("source", expSrc, instrSource);
                assert (vector == expVec)
                else reportMismatch("vector", expVec, vector);
            end

            // Model update for that edge
            if (lastNmi && !modelNmiPrev)
                modelNmiLatch = 1'b1;
            else if (captured && expSrc == srcNmi)
                modelNmiLatch = 1'b0;
            modelNmiPrev = lastNmi;
            if (captured && expSrc == srcReset)
                modelResetPending = 1'b0;
            if (lastJump)
                expPc = lastTarget;
            else if (captured && expSrc == srcNone)
                expPc = expPc + addrT'(1);

            // Four-phase rules on both buses
            if (memReq && !lastMemReq)
                assert (!lastMemAck) else flagProtocol("memReq rose before memAck fell");
            if (memReq && lastMemReq)
                assert (memAddr == lastMemAddr)
                else flagProtocol("memAddr changed while memReq was high");
            if (coreAck && !lastCoreAck)
                assert (lastCoreReq) else flagProtocol("coreAck rose without coreReq");
            if (!coreAck && lastCoreAck)
                assert (!lastCoreReq) else flagProtocol("coreAck fell while coreReq was high");
            if (coreAck && lastCoreAck)
                assert (instruction == lastInstr && instrSource == lastSource
                        && vector == lastVector)
                else flagProtocol("core outputs changed while coreAck was high");
        end

        sampleValid = 1'b1;
        lastReset = resetDetected;
        lastNmi = nonMaskableInterrupt;
        lastIrq = interruptRequest;
        lastIFlag = processStatusRegIFlag;
        lastJump = jumpValid;
        lastTarget = jumpTarget;
        lastEnable = enableIFlag;
        lastCoreReq = coreReq;
        lastCoreAck = coreAck;
        lastMemReq = memReq;
        lastMemAck = memAck;
        lastMemAddr = memAddr;
        lastInstr = instruction;
        lastSource = instrSource;
        lastVector = vector;
    end

    // Watchdog sized from the transaction count
    initial
    begin
        #(numTransactions * cyclesPerTransaction * clkPeriod);
        $display("Timeout, the core did not finish all transactions in time");
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        memAck = 1'b0;
        memData = '0;
        coreReq = 1'b0;
        jumpValid = 1'b0;
        jumpTarget = '0;
        // Reset, NMI and IRQ all pending for the first capture
        nonMaskableInterrupt = 1'b1;
        interruptRequest = 1'b1;
        processStatusRegIFlag = 1'b0;
        sampleValid = 1'b0;
        valueErrors = 0;
        protocolErrors = 0;
        captureCount = 0;
        txnCount = 0;
        void'($urandom(32'hfbf1_f50e));
        for (int addr = 0; addr < 65536; addr++)
            mem[addr] = opcodeT'($urandom);

        // Memory and sideband drivers run beside the core requester
        fork
            runMemory();
            driveInterrupts();
        join_none
        runCore();
        repeat (2) @(negedge clk);

        assert (captureCount == numTransactions)
        else reportMismatch("capture count", numTransactions, captureCount);
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/frontEndPkg.sv
design/opcodeFetcher.sv
design/interruptInjector.sv
design/instructionLoader.sv
design/instructionDispatcher.sv
design/instructionFrontEnd.sv
verification/clockGen.sv
verification/frontEndTb.sv

// File: Bender.yml
package:
  name: instruction_front_end

sources:
  - include_dirs:
      - design
    files:
      - design/frontEndPkg.sv
      - design/opcodeFetcher.sv
      - design/interruptInjector.sv
      - design/instructionLoader.sv
      - design/instructionDispatcher.sv
      - design/instructionFrontEnd.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/clockGen.sv
      - verification/frontEndTb.sv
